/* all.f */
+incdir+hdl
hdl/cache_pkg.sv
hdl/mem_pkg.sv
hdl/tag_match.sv
hdl/lru_tracker.sv
hdl/cache_controller.sv
hdl/line_memory.sv
hdl/cache_subsystem.sv
sim/cache_tb.sv

/* hdl/cache_consts.svh */
// Sizes are fixed for a 4-line cache of 16-byte lines; memory keeps only the low 8 tag bits
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Requester address and data word
`define CACHE_ADDR_WIDTH 32
`define CACHE_WORD_WIDTH 32

// Line geometry
`define CACHE_WORDS_PER_LINE 4
`define CACHE_NUM_LINES 4
`define CACHE_BYTE_OFS_WIDTH 2
`define CACHE_WORD_OFS_WIDTH 2
`define CACHE_TAG_WIDTH (`CACHE_ADDR_WIDTH - `CACHE_BYTE_OFS_WIDTH - `CACHE_WORD_OFS_WIDTH)
`define CACHE_LINE_WIDTH (`CACHE_WORD_WIDTH * `CACHE_WORDS_PER_LINE)

// Backing store, tag bits above the index alias onto the same line
`define MEM_LINES 256
`define MEM_INDEX_WIDTH 8

// Cycles from read strobe to rvalid
`define MEM_READ_LATENCY 3

`endif

/* hdl/cache_controller.sv */
// Blocking controller, one access in flight; access while busy is ignored and flagged
`timescale 1ns/100ps
`default_nettype none

`include "cache_consts.svh"

module cache_controller (
    input  logic                                             clk,
    input  logic                                             reset,
    input  logic                                             access,
    input  cache_pkg::cache_req_t                            req,
    output logic                                             busy,
    output logic                                             done,
    output cache_pkg::cache_resp_t                           resp,
    output logic [`CACHE_TAG_WIDTH-1:0]                      lookup_tag,
    output logic [`CACHE_NUM_LINES-1:0][`CACHE_TAG_WIDTH-1:0] stored_tags,
    output logic [`CACHE_NUM_LINES-1:0]                      valid_bits,
    input  logic                                             hit_any,
    input  cache_pkg::line_idx_t                             hit_line,
    output logic                                             touch,
    output cache_pkg::line_idx_t                             touch_line,
    input  cache_pkg::line_idx_t                             victim,
    output mem_pkg::mem_req_t                                mem_req,
    input  mem_pkg::mem_resp_t                               mem_resp
);

    cache_pkg::ctrl_state_e state;
    cache_pkg::cache_req_t  req_q;

    // Line storage
    mem_pkg::line_t                                   data_array [`CACHE_NUM_LINES];
    logic [`CACHE_NUM_LINES-1:0][`CACHE_TAG_WIDTH-1:0] tag_array;
    logic [`CACHE_NUM_LINES-1:0]                      valid_array;
    logic [`CACHE_NUM_LINES-1:0]                      dirty_array;

    // Line chosen in LOOKUP, hit or victim
    cache_pkg::line_idx_t sel_line;
    logic                 hit_q;

    // Memory request registers
    logic                        mem_rd;
    logic                        mem_wr;
    logic [`CACHE_TAG_WIDTH-1:0] mem_addr_q;
    mem_pkg::line_t              mem_wline_q;

    // Response, live during COMPLETE and held afterwards
    cache_pkg::cache_resp_t resp_live;
    cache_pkg::cache_resp_t resp_hold;

    // Address fields of the latched request
    logic [`CACHE_WORD_OFS_WIDTH-1:0] word_ofs;
    logic [`CACHE_BYTE_OFS_WIDTH-1:0] byte_ofs;
    logic [`CACHE_WORD_WIDTH-1:0]     sel_word;
    logic [7:0]                       sel_byte;

    // Transition decode shared by control and payload
    logic accept;
    logic go_wb;
    logic go_fill;
    logic fill_done;
    logic do_write;

    assign lookup_tag = req_q.addr[`CACHE_ADDR_WIDTH-1 -: `CACHE_TAG_WIDTH];
    assign word_ofs   = req_q.addr[`CACHE_BYTE_OFS_WIDTH +: `CACHE_WORD_OFS_WIDTH];
    assign byte_ofs   = req_q.addr[`CACHE_BYTE_OFS_WIDTH-1:0];

    // Busy drops during COMPLETE so a back-to-back access can be taken
    assign busy = (state != cache_pkg::IDLE) && (state != cache_pkg::COMPLETE);
    assign done = (state == cache_pkg::COMPLETE);

    assign accept = access && !busy;
    // Dirty victim needs a write-back before the fill
    assign go_wb = (state == cache_pkg::LOOKUP) && !hit_any &&
                   valid_array[victim] && dirty_array[victim];
    assign go_fill = ((state == cache_pkg::LOOKUP) && !hit_any && !go_wb) ||
                     (state == cache_pkg::WRITEBACK);
    assign fill_done = (state == cache_pkg::FILL_WAIT) && mem_resp.rvalid;
    assign do_write  = (state == cache_pkg::COMPLETE) && (req_q.op == cache_pkg::OP_WRITE);

    // Word and byte picked from the chosen line
    assign sel_word = data_array[sel_line][word_ofs * `CACHE_WORD_WIDTH +: `CACHE_WORD_WIDTH];
    assign sel_byte = sel_word[byte_ofs * 8 +: 8];

    always_comb begin
        resp_live.hit  = hit_q;
        resp_live.miss = !hit_q;
        if (req_q.op == cache_pkg::OP_READ) begin
            // Byte reads come back zero-extended
            resp_live.rdata = req_q.byte_op ?
                {{(`CACHE_WORD_WIDTH - 8){1'b0}}, sel_byte} : sel_word;
        end else begin
            resp_live.rdata = '0;
        end
    end

    assign resp = done ? resp_live : resp_hold;

    // LRU update on completion
    assign touch      = done;
    assign touch_line = sel_line;

    assign stored_tags = tag_array;
    assign valid_bits  = valid_array;

    assign mem_req.line_addr = mem_addr_q;
    assign mem_req.wline     = mem_wline_q;
    assign mem_req.rd        = mem_rd;
    assign mem_req.wr        = mem_wr;

    // Control state
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= cache_pkg::IDLE;
            valid_array <= '0;
            dirty_array <= '0;
            sel_line    <= '0;
            hit_q       <= 1'b0;
            mem_rd      <= 1'b0;
            mem_wr      <= 1'b0;
            resp_hold   <= '0;
        end else begin
            // Strobes last one cycle
            mem_rd <= go_fill;
            mem_wr <= go_wb;
            case (state)
                cache_pkg::IDLE: begin
                    if (access) begin
                        state <= cache_pkg::LOOKUP;
                    end
                end
                cache_pkg::LOOKUP: begin
                    hit_q <= hit_any;
                    if (hit_any) begin
                        sel_line <= hit_line;
                        state    <= cache_pkg::COMPLETE;
                    end else begin
                        sel_line <= victim;
                        state    <= go_wb ? cache_pkg::WRITEBACK : cache_pkg::FILL_WAIT;
                    end
                end
                cache_pkg::WRITEBACK: begin
                    state <= cache_pkg::FILL_WAIT;
                end
                cache_pkg::FILL_WAIT: begin
                    if (mem_resp.rvalid) begin
                        // Freshly filled line is clean
                        valid_array[sel_line] <= 1'b1;
                        dirty_array[sel_line] <= 1'b0;
                        state                 <= cache_pkg::COMPLETE;
                    end
                end
                cache_pkg::COMPLETE: begin
                    resp_hold <= resp_live;
                    if (req_q.op == cache_pkg::OP_WRITE) begin
                        dirty_array[sel_line] <= 1'b1;
                    end
                    state <= access ? cache_pkg::LOOKUP : cache_pkg::IDLE;
                end
                default: begin
                    state <= cache_pkg::IDLE;
                end
            endcase
        end
    end

    // Payload, no reset
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
        if (go_wb) begin
            mem_addr_q  <= tag_array[victim];
            mem_wline_q <= data_array[victim];
        end else if (go_fill) begin
            mem_addr_q <= lookup_tag;
        end
        if (fill_done) begin
            data_array[sel_line] <= mem_resp.rline;
            tag_array[sel_line]  <= lookup_tag;
        end
        if (do_write) begin
            if (req_q.byte_op) begin
                data_array[sel_line][word_ofs * `CACHE_WORD_WIDTH + byte_ofs * 8 +: 8]
                    <= req_q.wdata[7:0];
            end else begin
                data_array[sel_line][word_ofs * `CACHE_WORD_WIDTH +: `CACHE_WORD_WIDTH]
                    <= req_q.wdata;
            end
        end
    end

    // Requester must wait for busy low
    assert property (@(posedge clk) disable iff (reset) busy |-> !access)
        else $error("cache_controller: access while busy");

    // One done per accepted access
    assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("cache_controller: done longer than one cycle");

endmodule

`default_nettype wire

/* hdl/cache_pkg.sv */
// Requester-side types; op encoding is write = 0, read = 1
`default_nettype none

`include "cache_consts.svh"

package cache_pkg;

    // Requested operation
    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } cache_op_e;

    // One access, sampled with the access pulse
    typedef struct packed {
        logic [`CACHE_ADDR_WIDTH-1:0] addr;
        logic [`CACHE_WORD_WIDTH-1:0] wdata;
        cache_op_e                    op;
        // Byte access uses wdata[7:0] only
        logic                         byte_op;
    } cache_req_t;

    // Result, valid from done until the next done
    typedef struct packed {
        logic [`CACHE_WORD_WIDTH-1:0] rdata;
        logic                         hit;
        logic                         miss;
    } cache_resp_t;

    // Blocking controller FSM
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        LOOKUP    = 3'd1,
        WRITEBACK = 3'd2,
        FILL_WAIT = 3'd3,
        COMPLETE  = 3'd4
    } ctrl_state_e;

    // LRU age, 3 is most recent
    typedef logic [1:0] lru_count_t;

    // Line number inside the cache
    typedef logic [1:0] line_idx_t;

endpackage

`default_nettype wire

/* hdl/cache_subsystem.sv */
// Top level; requester waits for busy low before pulsing access, there is no back-pressure
`timescale 1ns/100ps
`default_nettype none

`include "cache_consts.svh"

module cache_subsystem (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   access,
    input  cache_pkg::cache_req_t  req,
    output logic                   busy,
    output logic                   done,
    output cache_pkg::cache_resp_t resp
);

    // Tag lookup path
    logic [`CACHE_TAG_WIDTH-1:0]                      lookup_tag;
    logic [`CACHE_NUM_LINES-1:0][`CACHE_TAG_WIDTH-1:0] stored_tags;
    logic [`CACHE_NUM_LINES-1:0]                      valid_bits;
    logic                                             hit_any;
    cache_pkg::line_idx_t                             hit_line;

    // LRU path
    logic                 touch;
    cache_pkg::line_idx_t touch_line;
    cache_pkg::line_idx_t victim;

    // Backing memory path
    mem_pkg::mem_req_t  mem_req;
    mem_pkg::mem_resp_t mem_resp;

    cache_controller u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .access      (access),
        .req         (req),
        .busy        (busy),
        .done        (done),
        .resp        (resp),
        .lookup_tag  (lookup_tag),
        .stored_tags (stored_tags),
        .valid_bits  (valid_bits),
        .hit_any     (hit_any),
        .hit_line    (hit_line),
        .touch       (touch),
        .touch_line  (touch_line),
        .victim      (victim),
        .mem_req     (mem_req),
        .mem_resp    (mem_resp)
    );

    tag_match u_match (
        .tag         (lookup_tag),
        .stored_tags (stored_tags),
        .valid       (valid_bits),
        .hit_any     (hit_any),
        .hit_line    (hit_line)
    );

    lru_tracker u_lru (
        .clk        (clk),
        .reset      (reset),
        .touch      (touch),
        .touch_line (touch_line),
        .victim     (victim)
    );

    line_memory u_mem (
        .clk      (clk),
        .reset    (reset),
        .mem_req  (mem_req),
        .mem_resp (mem_resp)
    );

endmodule

`default_nettype wire

/* hdl/line_memory.sv */
// Only the low 8 bits of the line address index the store; unwritten lines read as zero
`timescale 1ns/100ps
`default_nettype none

`include "cache_consts.svh"

module line_memory (
    input  logic               clk,
    input  logic               reset,
    input  mem_pkg::mem_req_t  mem_req,
    output mem_pkg::mem_resp_t mem_resp
);

    mem_pkg::line_t mem_array [`MEM_LINES];

    // Per-line written flag, cleared by reset instead of sweeping the array
    logic [`MEM_LINES-1:0] written;

    logic [`MEM_INDEX_WIDTH-1:0] index;

    // Read return pipeline
    logic [`MEM_READ_LATENCY-1:0] valid_pipe;
    mem_pkg::line_t               data_pipe [`MEM_READ_LATENCY];

    assign index = mem_req.line_addr[`MEM_INDEX_WIDTH-1:0];

    // Storage itself
    always_ff @(posedge clk) begin
        if (mem_req.wr) begin
            mem_array[index] <= mem_req.wline;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            written    <= '0;
            valid_pipe <= '0;
        end else begin
            if (mem_req.wr) begin
                written[index] <= 1'b1;
            end
            valid_pipe <= {valid_pipe[`MEM_READ_LATENCY-2:0], mem_req.rd};
        end
    end

    // Stage 0 samples the array, later stages only delay
    always_ff @(posedge clk) begin
        data_pipe[0] <= written[index] ? mem_array[index] : '0;
        for (int k = 1; k < `MEM_READ_LATENCY; k++) begin
            data_pipe[k] <= data_pipe[k-1];
        end
    end

    assign mem_resp.rline  = data_pipe[`MEM_READ_LATENCY-1];
    assign mem_resp.rvalid = valid_pipe[`MEM_READ_LATENCY-1];

    // Controller separates write-back and fill by a cycle
    assert property (@(posedge clk) disable iff (reset) !(mem_req.rd && mem_req.wr))
        else $error("line_memory: read and write strobes together");

endmodule

`default_nettype wire

/* hdl/lru_tracker.sv */
// Counters stay a permutation of 0..3; victim is combinational from the current counters
`timescale 1ns/100ps
`default_nettype none

`include "cache_consts.svh"

module lru_tracker (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 touch,
    input  cache_pkg::line_idx_t touch_line,
    output cache_pkg::line_idx_t victim
);

    // Age per line, 0 is least recent
    cache_pkg::lru_count_t count [`CACHE_NUM_LINES];

    // Which ages are present, for the permutation check
    logic [`CACHE_NUM_LINES-1:0] seen;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // Line i starts with age i, so line 0 goes first
            for (int i = 0; i < `CACHE_NUM_LINES; i++) begin
                count[i] <= cache_pkg::lru_count_t'(i);
            end
        end else if (touch) begin
            for (int i = 0; i < `CACHE_NUM_LINES; i++) begin
                if (i == int'(touch_line)) begin
                    // Touched line becomes most recent
                    count[i] <= cache_pkg::lru_count_t'(`CACHE_NUM_LINES - 1);
                end else if (count[i] > count[touch_line]) begin
                    // Younger lines slide down one step
                    count[i] <= count[i] - 1'b1;
                end
            end
        end
    end

    // Victim is the line aged 0
    always_comb begin
        victim = '0;
        for (int i = 0; i < `CACHE_NUM_LINES; i++) begin
            if (count[i] == '0) begin
                victim = cache_pkg::line_idx_t'(i);
            end
        end
    end

    always_comb begin
        seen = '0;
        for (int i = 0; i < `CACHE_NUM_LINES; i++) begin
            seen[count[i]] = 1'b1;
        end
    end

    // Every age appears once, across any sequence of touches
    assert property (@(posedge clk) disable iff (reset) &seen)
        else $error("lru_tracker: counters are not a permutation");

endmodule

`default_nettype wire

/* hdl/mem_pkg.sv */
// Memory-side types; one request moves a whole line, strobes are single-cycle pulses
`default_nettype none

`include "cache_consts.svh"

package mem_pkg;

    // Full cache line
    typedef logic [`CACHE_LINE_WIDTH-1:0] line_t;

    // Line request toward the backing store
    typedef struct packed {
        // Line address is the cache tag
        logic [`CACHE_TAG_WIDTH-1:0] line_addr;
        line_t                       wline;
        logic                        rd;
        logic                        wr;
    } mem_req_t;

    // Read return, rvalid pulses once per read strobe
    typedef struct packed {
        line_t rline;
        logic  rvalid;
    } mem_resp_t;

endpackage

`default_nettype wire

/* hdl/tag_match.sv */
// Purely combinational; assumes the controller never holds two valid lines with one tag
`timescale 1ns/100ps
`default_nettype none

`include "cache_consts.svh"

module tag_match (
    input  logic [`CACHE_TAG_WIDTH-1:0]                      tag,
    input  logic [`CACHE_NUM_LINES-1:0][`CACHE_TAG_WIDTH-1:0] stored_tags,
    input  logic [`CACHE_NUM_LINES-1:0]                      valid,
    output logic                                             hit_any,
    output cache_pkg::line_idx_t                             hit_line
);

    // One comparator per line
    logic [`CACHE_NUM_LINES-1:0] match;

    for (genvar i = 0; i < `CACHE_NUM_LINES; i++) begin : g_cmp
        // Invalid lines never match, whatever their stale tag
        assign match[i] = valid[i] && (stored_tags[i] == tag);
    end

    assign hit_any = |match;

    // Priority encoder, lowest index wins
    always_comb begin
        hit_line = '0;
        for (int i = `CACHE_NUM_LINES - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_line = cache_pkg::line_idx_t'(i);
            end
        end
    end

    // Fills only happen on a miss, so a tag lives in one line at most
    always_comb begin
        assert ($onehot0(match))
            else $error("tag_match: tag %h matches lines %b", tag, match);
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the cache testbench with Verilator, runs it and scans the log for the fail message.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module cache_tb -f all.f \
    --Mdir obj_dir -o cache_tb_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/cache_tb_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$SIM_LOG"; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" "$SIM_LOG"; then
    echo "Simulation log holds no final verdict"
    exit 1
fi
exit 0

/* sim/cache_tb.sv */
// Table addresses stay below 0x1000 so the 8-bit memory index never aliases two lines
`timescale 1ns/100ps
`default_nettype none

`include "cache_consts.svh"

module cache_tb;

    // Outcome class of one access
    typedef enum logic [1:0] {
        KIND_HIT   = 2'd0,
        KIND_MISS  = 2'd1,
        KIND_DIRTY = 2'd2
    } access_kind_e;

    // One table row, either an access or a mid-run reset
    typedef struct packed {
        logic                  do_reset;
        cache_pkg::cache_req_t req;
        access_kind_e          kind;
    } row_t;

    // Cycles from the sampling edge of access to the done cycle
    localparam int HIT_LAT      = 2;
    localparam int MISS_LAT     = 2 + `MEM_READ_LATENCY + 1;
    localparam int DIRTY_LAT    = MISS_LAT + 1;
    localparam int LINE_BYTES   = `CACHE_LINE_WIDTH / 8;
    localparam int WORD_BYTES   = `CACHE_WORD_WIDTH / 8;
    localparam int MEM_BYTES    = `MEM_LINES * LINE_BYTES;
    // Issue edge plus the checks after done
    localparam int ROW_OVERHEAD = 4;

    logic                   clk;
    logic                   reset;
    logic                   access;
    cache_pkg::cache_req_t  req;
    logic                   busy;
    logic                   done;
    cache_pkg::cache_resp_t resp;

    row_t rows[$];
    int   errors;
    int   checks;
    int   accepted;
    int   timeout_limit;
    int   done_seen   = 0;
    int   cycle_count = 0;

    // Reference cache and flat byte memory
    logic [7:0]                  ref_mem   [MEM_BYTES];
    logic                        ref_valid [`CACHE_NUM_LINES];
    logic                        ref_dirty [`CACHE_NUM_LINES];
    logic [`CACHE_TAG_WIDTH-1:0] ref_tag   [`CACHE_NUM_LINES];
    logic [7:0]                  ref_data  [`CACHE_NUM_LINES][LINE_BYTES];
    int                          ref_age   [`CACHE_NUM_LINES];

    cache_subsystem cache_subsystem_i (
        .clk    (clk),
        .reset  (reset),
        .access (access),
        .req    (req),
        .busy   (busy),
        .done   (done),
        .resp   (resp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Run limit, one worst-case row per table entry
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("Timeout: run did not finish within %0d cycles", timeout_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Counts every done pulse, compared with accepted accesses at the end
    always @(negedge clk) begin
        if (done) begin
            done_seen <= done_seen + 1;
        end
    end

    function automatic string kind_name(input access_kind_e kind);
        case (kind)
            KIND_HIT:  return "hit";
            KIND_MISS: return "clean miss";
            default:   return "dirty miss";
        endcase
    endfunction

    // Empty cache, zero memory, line i aged i
    function automatic void model_reset();
        for (int a = 0; a < MEM_BYTES; a++) begin
            ref_mem[a] = 8'h00;
        end
        for (int i = 0; i < `CACHE_NUM_LINES; i++) begin
            ref_valid[i] = 1'b0;
            ref_dirty[i] = 1'b0;
            ref_tag[i]   = '0;
            ref_age[i]   = i;
            for (int b = 0; b < LINE_BYTES; b++) begin
                ref_data[i][b] = 8'h00;
            end
        end
    endfunction

    // Predicts outcome and response, then updates the model state
    function automatic void model_access(input cache_pkg::cache_req_t r,
                                         output cache_pkg::cache_resp_t exp,
                                         output access_kind_e kind);
        logic [`CACHE_TAG_WIDTH-1:0] tag;
        int ofs;
        int wbase;
        int line;
        int mbase;
        int old_age;
        tag   = r.addr[`CACHE_ADDR_WIDTH-1 -: `CACHE_TAG_WIDTH];
        ofs   = int'(r.addr[3:0]);
        wbase = ofs - (ofs % WORD_BYTES);
        line  = -1;
        kind  = KIND_HIT;
        // Lowest matching line wins
        for (int i = 0; i < `CACHE_NUM_LINES; i++) begin
            if (line < 0 && ref_valid[i] && ref_tag[i] == tag) begin
                line = i;
            end
        end
        if (line < 0) begin
            for (int i = 0; i < `CACHE_NUM_LINES; i++) begin
                if (ref_age[i] == 0) begin
                    line = i;
                end
            end
            if (ref_valid[line] && ref_dirty[line]) begin
                kind  = KIND_DIRTY;
                mbase = int'(ref_tag[line][`MEM_INDEX_WIDTH-1:0]) * LINE_BYTES;
                for (int b = 0; b < LINE_BYTES; b++) begin
                    ref_mem[mbase + b] = ref_data[line][b];
                end
            end else begin
                kind = KIND_MISS;
            end
            // Refill from memory, line comes in clean
            mbase = int'(tag[`MEM_INDEX_WIDTH-1:0]) * LINE_BYTES;
            for (int b = 0; b < LINE_BYTES; b++) begin
                ref_data[line][b] = ref_mem[mbase + b];
            end
            ref_valid[line] = 1'b1;
            ref_dirty[line] = 1'b0;
            ref_tag[line]   = tag;
        end
        exp      = '0;
        exp.hit  = (kind == KIND_HIT);
        exp.miss = (kind != KIND_HIT);
        if (r.op == cache_pkg::OP_WRITE) begin
            if (r.byte_op) begin
                ref_data[line][ofs] = r.wdata[7:0];
            end else begin
                for (int b = 0; b < WORD_BYTES; b++) begin
                    ref_data[line][wbase + b] = r.wdata[8*b +: 8];
                end
            end
            ref_dirty[line] = 1'b1;
        end else if (r.byte_op) begin
            // Zero-extended byte
            exp.rdata[7:0] = ref_data[line][ofs];
        end else begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                exp.rdata[8*b +: 8] = ref_data[line][wbase + b];
            end
        end
        // LRU touch, younger lines step down
        old_age = ref_age[line];
        for (int i = 0; i < `CACHE_NUM_LINES; i++) begin
            if (ref_age[i] > old_age) begin
                ref_age[i] = ref_age[i] - 1;
            end
        end
        ref_age[line] = `CACHE_NUM_LINES - 1;
    endfunction

    task automatic check_resp(input string what, input cache_pkg::cache_resp_t got,
                              input cache_pkg::cache_resp_t exp, input logic with_data);
        checks++;
        if (got.hit !== exp.hit) begin
            $display("MISMATCH %s.hit got %h exp %h", what, got.hit, exp.hit);
            errors++;
        end
        if (got.miss !== exp.miss) begin
            $display("MISMATCH %s.miss got %h exp %h", what, got.miss, exp.miss);
            errors++;
        end
        if (with_data && got.rdata !== exp.rdata) begin
            $display("MISMATCH %s.rdata got %h exp %h", what, got.rdata, exp.rdata);
            errors++;
        end
    endtask

    task automatic check_busy(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH %s got %h exp %h", what, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            $display("MISMATCH %s got %0h exp %0h", what, got, exp);
            errors++;
        end
    endtask

    function automatic void add_row(input logic [31:0] addr, input logic [31:0] data,
                                    input cache_pkg::cache_op_e op, input logic byte_op,
                                    input access_kind_e kind);
        row_t row;
        row.do_reset    = 1'b0;
        row.req.addr    = addr;
        row.req.wdata   = data;
        row.req.op      = op;
        row.req.byte_op = byte_op;
        row.kind        = kind;
        rows.push_back(row);
    endfunction

    function automatic void add_reset_row();
        row_t row;
        row          = '0;
        row.do_reset = 1'b1;
        rows.push_back(row);
    endfunction

    // Line A at 0x100, B at 0x200, then C, D, E fill and evict
    task automatic build_table();
        add_row(32'h100, 32'h0, cache_pkg::OP_READ, 1'b0, KIND_MISS);
        add_row(32'h104, 32'h0, cache_pkg::OP_READ, 1'b0, KIND_HIT);
        add_row(32'h208, 32'hdeadbeef, cache_pkg::OP_WRITE, 1'b0, KIND_MISS);
        add_row(32'h208, 32'h0, cache_pkg::OP_READ, 1'b0, KIND_HIT);
        add_row(32'h200, 32'h0, cache_pkg::OP_READ, 1'b0, KIND_HIT);
        add_row(32'h20c, 32'h0, cache_pkg::OP_READ, 1'b0, KIND_HIT);
        add_row(32'h209, 32'h5a, cache_pkg::OP_WRITE, 1'b1, KIND_HIT);
        add_row(32'h208, 32'h0, cache_pkg::OP_READ, 1'b0, KIND_HIT);
        add_row(32'h209, 32'h0, cache_pkg::OP_READ, 1'b1, KIND_HIT);
        add_row(32'h20b, 32'h0, cache_pkg::OP_READ, 1'b1, KIND_HIT);
        // Refresh A so dirty B becomes the oldest
        add_row(32'h100, 32'h0, cache_pkg::OP_READ, 1'b0, KIND_HIT);
        add_row(32'h300, $urandom(), cache_pkg::OP_WRITE, 1'b0, KIND_MISS);
        add_row(32'h400, $urandom(), cache_pkg::OP_WRITE, 1'b0, KIND_MISS);
        add_row(32'h504, $urandom(), cache_pkg::OP_WRITE, 1'b0, KIND_DIRTY);
        // B comes back from memory after its write-back
        add_row(32'h208, 32'h0, cache_pkg::OP_READ, 1'b0, KIND_MISS);
        add_row(32'h20b, 32'h0, cache_pkg::OP_READ, 1'b1, KIND_HIT);
        add_row(32'h300, 32'h0, cache_pkg::OP_READ, 1'b0, KIND_HIT);
        add_row(32'h504, 32'h0, cache_pkg::OP_READ, 1'b0, KIND_HIT);
        add_reset_row();
        add_row(32'h208, 32'h0, cache_pkg::OP_READ, 1'b0, KIND_MISS);
        add_row(32'h20c, 32'h0, cache_pkg::OP_READ, 1'b0, KIND_HIT);
        add_row(32'h600, $urandom(), cache_pkg::OP_WRITE, 1'b0, KIND_MISS);
        add_row(32'h600, 32'h0, cache_pkg::OP_READ, 1'b0, KIND_HIT);
        add_row(32'h603, $urandom(), cache_pkg::OP_WRITE, 1'b1, KIND_HIT);
        add_row(32'h600, 32'h0, cache_pkg::OP_READ, 1'b0, KIND_HIT);
    endtask

    task automatic run_reset(input int idx);
        int err_before;
        err_before = errors;
        @(posedge clk);
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        // Cache state and memory both start over
        model_reset();
        @(negedge clk);
        check_busy("busy after reset", busy, 1'b0);
        check_busy("done after reset", done, 1'b0);
        $display("test %0d: reset -> %s", idx, (errors == err_before) ? "ok" : "FAILED");
    endtask

    task automatic run_row(input int idx, input row_t row);
        cache_pkg::cache_resp_t exp;
        access_kind_e           kind;
        int                     cycles;
        int                     exp_lat;
        int                     err_before;
        logic                   got_done;
        logic                   is_read;
        err_before = errors;
        is_read    = (row.req.op == cache_pkg::OP_READ);
        model_access(row.req, exp, kind);
        if (kind != row.kind) begin
            $display("Row %0d: table expects a %s but the reference model predicts a %s",
                     idx, kind_name(row.kind), kind_name(kind));
            errors++;
        end
        exp_lat = (kind == KIND_HIT) ? HIT_LAT : (kind == KIND_MISS) ? MISS_LAT : DIRTY_LAT;
        @(posedge clk);
        access <= 1'b1;
        req    <= row.req;
        @(posedge clk);
        access <= 1'b0;
        accepted++;
        cycles   = 0;
        got_done = 1'b0;
        while (!got_done && cycles < DIRTY_LAT + 2) begin
            @(negedge clk);
            cycles++;
            if (cycles == 1) begin
                check_busy("busy after accept", busy, 1'b1);
            end
            got_done = done;
        end
        if (!got_done) begin
            $display("Row %0d: done did not arrive within %0d cycles", idx, cycles);
            errors++;
        end else begin
            check_count("latency", cycles, exp_lat);
            check_busy("busy at done", busy, 1'b0);
            check_resp("resp", resp, exp, is_read);
            // Single done pulse, response held afterwards
            @(negedge clk);
            check_busy("done after pulse", done, 1'b0);
            check_busy("busy after done", busy, 1'b0);
            check_resp("resp held", resp, exp, is_read);
        end
        $display("test %0d: %s %s addr %h %s -> %s", idx, is_read ? "read" : "write",
                 row.req.byte_op ? "byte" : "word", row.req.addr, kind_name(kind),
                 (errors == err_before) ? "ok" : "FAILED");
    endtask

    initial begin
        reset    = 1'b1;
        access   = 1'b0;
        req      = '0;
        errors   = 0;
        checks   = 0;
        accepted = 0;
        void'($urandom(32'h3b25));
        build_table();
        timeout_limit = rows.size() * (DIRTY_LAT + ROW_OVERHEAD) + 50;
        model_reset();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_busy("busy after reset", busy, 1'b0);
        check_busy("done after reset", done, 1'b0);
        foreach (rows[i]) begin
            if (rows[i].do_reset) begin
                run_reset(i);
            end else begin
                run_row(i, rows[i]);
            end
        end
        check_count("done pulses", done_seen, accepted);
        $display("Summary: %0d tests, %0d checks, %0d errors", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
